/* Makefile */
# Verilator build and run of the APB subsystem testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing
TOP       = tb_apb_subsystem
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG) || (echo "No result line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
design/apb_pkg.sv
design/apb_requester.sv
design/apb_decoder.sv
design/apb_regbank.sv
design/apb_subsystem_top.sv
testbench/tb_apb_subsystem.sv

/* design/apb_decoder.sv */
// APB address decoder.
// Splits the address space by the region field of paddr, passes psel
// to one bank and steers that bank's completion back. Unmapped
// regions complete at once with an error, and no bank sees them.

`default_nettype none

module apb_decoder (
	input  apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_cpl_t apb_cpl,
	output apb_pkg::apb_req_t bank_a_req,
	input  apb_pkg::apb_cpl_t bank_a_cpl,
	output apb_pkg::apb_req_t bank_b_req,
	input  apb_pkg::apb_cpl_t bank_b_cpl
);

	// Region field of the address
	logic [apb_pkg::ADDR_BITS-apb_pkg::REGION_LSB-1:0] region;
	logic hit_a;
	logic hit_b;

	assign region = apb_req.paddr[apb_pkg::ADDR_BITS-1:apb_pkg::REGION_LSB];
	assign hit_a  = (region == apb_pkg::REGION_BANK_A);
	assign hit_b  = (region == apb_pkg::REGION_BANK_B);

	// ----------------------------------------------------------------------
	// Request fan-out
	// ----------------------------------------------------------------------
	// Same payload to both banks, psel only to the hit
	always_comb begin
		bank_a_req      = apb_req;
		bank_a_req.psel = apb_req.psel & hit_a;
		bank_b_req      = apb_req;
		bank_b_req.psel = apb_req.psel & hit_b;
	end

	// ----------------------------------------------------------------------
	// Completion steering
	// ----------------------------------------------------------------------
	always_comb begin
		if (hit_a) begin
			apb_cpl = bank_a_cpl;
		end else if (hit_b) begin
			apb_cpl = bank_b_cpl;
		end else begin
			// Unmapped, answer here with zero wait states
			apb_cpl.prdata  = '0;
			apb_cpl.pready  = 1'b1;
			apb_cpl.pslverr = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/apb_pkg.sv */
// Shared types and constants for the APB subsystem.
// Every RTL file refers to these through scoped names, so this package
// is compiled before any module that uses it.

`default_nettype none

package apb_pkg;

	// ----------------------------------------------------------------------
	// Address map and bus widths
	// ----------------------------------------------------------------------
	localparam int ADDR_BITS  = 12;
	localparam int DATA_BITS  = 32;
	localparam int STRB_BITS  = DATA_BITS / 8;

	// Region field is paddr[11:8]
	localparam int REGION_LSB = 8;
	localparam logic [ADDR_BITS-REGION_LSB-1:0] REGION_BANK_A = 'd0;
	localparam logic [ADDR_BITS-REGION_LSB-1:0] REGION_BANK_B = 'd1;

	// Word index is paddr[5:2], paddr[7:6] must be zero
	localparam int BANK_WORDS = 16;

	// Wait states per bank, and width of the bank wait counter
	localparam int BANK_A_WAITS = 0;
	localparam int BANK_B_WAITS = 2;
	localparam int WAIT_BITS    = 4;

	// ----------------------------------------------------------------------
	// Enumerations
	// ----------------------------------------------------------------------
	typedef enum logic {
		APB_READ  = 1'b0,
		APB_WRITE = 1'b1
	} apb_dir_e;

	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		SETUP  = 2'd1,
		ACCESS = 2'd2,
		DONE   = 2'd3
	} apb_state_e;

	// ----------------------------------------------------------------------
	// Command side and APB side bundles
	// ----------------------------------------------------------------------
	// Command from the issuer, 49 bits
	typedef struct packed {
		apb_dir_e               dir;
		logic [ADDR_BITS-1:0]   addr;
		logic [DATA_BITS-1:0]   wdata;
		logic [STRB_BITS-1:0]   strb;
	} apb_cmd_t;

	// Response back to the issuer, 33 bits
	typedef struct packed {
		logic [DATA_BITS-1:0]   rdata;
		logic                   slverr;
	} apb_rsp_t;

	// Requester to completer signals, 51 bits
	typedef struct packed {
		logic                   psel;
		logic                   penable;
		logic                   pwrite;
		logic [ADDR_BITS-1:0]   paddr;
		logic [DATA_BITS-1:0]   pwdata;
		logic [STRB_BITS-1:0]   pstrb;
	} apb_req_t;

	// Completer to requester signals, 34 bits
	typedef struct packed {
		logic [DATA_BITS-1:0]   prdata;
		logic                   pready;
		logic                   pslverr;
	} apb_cpl_t;

endpackage

`default_nettype wire

/* design/apb_regbank.sv */
// APB register bank completer.
// Sixteen 32-bit words with byte strobes. WAITS sets how many access
// cycles pready is held low before the transfer completes. Offsets with
// paddr[7:6] nonzero are out of range and complete with pslverr.

`default_nettype none

module apb_regbank #(
	parameter int WAITS = 0
) (
	input  logic              CLK,
	input  logic              rst_n,
	input  apb_pkg::apb_req_t apb_req,
	output apb_pkg::apb_cpl_t apb_cpl
);

	// Word storage
	logic [apb_pkg::DATA_BITS-1:0] mem [apb_pkg::BANK_WORDS];

	// Address split
	logic [$clog2(apb_pkg::BANK_WORDS)-1:0] word_idx;
	logic                                    out_of_range;

	// Access phase tracking
	logic                         access;
	logic [apb_pkg::WAIT_BITS-1:0] wait_cnt;
	logic                         ready;

	assign word_idx     = apb_req.paddr[5:2];
	assign out_of_range = |apb_req.paddr[apb_pkg::REGION_LSB-1:6];
	assign access       = apb_req.psel & apb_req.penable;

	// Ready once the counter reaches the wait count
	assign ready = (wait_cnt == apb_pkg::WAIT_BITS'(WAITS));

	// ----------------------------------------------------------------------
	// Wait-state counter
	// ----------------------------------------------------------------------
	// Starts at zero on the first access cycle, back to zero on completion
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wait_cnt <= '0;
		end else if (access && !ready) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else begin
			wait_cnt <= '0;
		end
	end

	// ----------------------------------------------------------------------
	// Storage write
	// ----------------------------------------------------------------------
	// Bank is cleared by reset, writes land on the ready cycle only
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int w = 0; w < apb_pkg::BANK_WORDS; w++) begin
				mem[w] <= '0;
			end
		end else if (access && ready && apb_req.pwrite && !out_of_range) begin
			// Byte merge under pstrb
			for (int b = 0; b < apb_pkg::STRB_BITS; b++) begin
				if (apb_req.pstrb[b]) begin
					mem[word_idx][b*8 +: 8] <= apb_req.pwdata[b*8 +: 8];
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// Completion
	// ----------------------------------------------------------------------
	// Out-of-range reads give zero data
	assign apb_cpl.prdata  = out_of_range ? '0 : mem[word_idx];
	assign apb_cpl.pready  = ready;
	assign apb_cpl.pslverr = out_of_range;

endmodule

`default_nettype wire

/* design/apb_requester.sv */
// APB requester.
// Takes one command at a time over a four-phase req/ack handshake,
// runs the APB setup and access phases for it and hands back the
// read data and error flag. The response is held until req drops.

`default_nettype none

module apb_requester (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              cmd_req,
	input  apb_pkg::apb_cmd_t cmd,
	output logic              cmd_ack,
	output apb_pkg::apb_rsp_t rsp,
	output apb_pkg::apb_req_t apb_req,
	input  apb_pkg::apb_cpl_t apb_cpl
);

	// ----------------------------------------------------------------------
	// State and registered command
	// ----------------------------------------------------------------------
	apb_pkg::apb_state_e state;
	apb_pkg::apb_state_e state_nxt;

	// Command copy, drives the APB payload for the whole transfer
	apb_pkg::apb_cmd_t cmd_q;

	// Completion seen on an access cycle
	logic xfer_done;

	assign xfer_done = (state == apb_pkg::ACCESS) && apb_cpl.pready;

	// Next state
	always_comb begin
		state_nxt = state;
		case (state)
			apb_pkg::IDLE: begin
				// Accept a new command
				if (cmd_req) begin
					state_nxt = apb_pkg::SETUP;
				end
			end
			apb_pkg::SETUP: begin
				// Setup lasts exactly one cycle
				state_nxt = apb_pkg::ACCESS;
			end
			apb_pkg::ACCESS: begin
				// Stay here while the completer stretches with pready
				if (apb_cpl.pready) begin
					state_nxt = apb_pkg::DONE;
				end
			end
			apb_pkg::DONE: begin
				// Wait for the issuer to withdraw the request
				if (!cmd_req) begin
					state_nxt = apb_pkg::IDLE;
				end
			end
			default: begin
				state_nxt = apb_pkg::IDLE;
			end
		endcase
	end

	// State register
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= apb_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Command capture on acceptance
	always_ff @(posedge CLK) begin
		if ((state == apb_pkg::IDLE) && cmd_req) begin
			cmd_q <= cmd;
		end
	end

	// Response capture on the completing access cycle
	always_ff @(posedge CLK) begin
		if (xfer_done) begin
			// Writes return zero data
			if (cmd_q.dir == apb_pkg::APB_READ) begin
				rsp.rdata <= apb_cpl.prdata;
			end else begin
				rsp.rdata <= '0;
			end
			rsp.slverr <= apb_cpl.pslverr;
		end
	end

	// ----------------------------------------------------------------------
	// Outputs
	// ----------------------------------------------------------------------
	assign cmd_ack = (state == apb_pkg::DONE);

	// psel covers setup and access, penable only access
	assign apb_req.psel    = (state == apb_pkg::SETUP) || (state == apb_pkg::ACCESS);
	assign apb_req.penable = (state == apb_pkg::ACCESS);
	assign apb_req.pwrite  = (cmd_q.dir == apb_pkg::APB_WRITE);
	assign apb_req.paddr   = cmd_q.addr;
	assign apb_req.pwdata  = cmd_q.wdata;
	assign apb_req.pstrb   = cmd_q.strb;

endmodule

`default_nettype wire

/* design/apb_subsystem_top.sv */
// Top level of the APB subsystem.
// One requester feeds the decoder, which serves two register banks
// that differ only in their wait states. The outside world sees only
// the req/ack command port.

`default_nettype none

module apb_subsystem_top (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              cmd_req,
	input  apb_pkg::apb_cmd_t cmd,
	output logic              cmd_ack,
	output apb_pkg::apb_rsp_t rsp
);

	// ----------------------------------------------------------------------
	// Internal buses
	// ----------------------------------------------------------------------
	// Requester side
	apb_pkg::apb_req_t req_bus;
	apb_pkg::apb_cpl_t cpl_bus;

	// Bank side
	apb_pkg::apb_req_t bank_a_req;
	apb_pkg::apb_cpl_t bank_a_cpl;
	apb_pkg::apb_req_t bank_b_req;
	apb_pkg::apb_cpl_t bank_b_cpl;

	// Command to APB conversion
	apb_requester u_requester (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.cmd_req (cmd_req),
		.cmd     (cmd),
		.cmd_ack (cmd_ack),
		.rsp     (rsp),
		.apb_req (req_bus),
		.apb_cpl (cpl_bus)
	);

	// Region decode
	apb_decoder u_decoder (
		.apb_req    (req_bus),
		.apb_cpl    (cpl_bus),
		.bank_a_req (bank_a_req),
		.bank_a_cpl (bank_a_cpl),
		.bank_b_req (bank_b_req),
		.bank_b_cpl (bank_b_cpl)
	);

	// Region 0, no wait states
	apb_regbank #(
		.WAITS (apb_pkg::BANK_A_WAITS)
	) u_bank_a (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.apb_req (bank_a_req),
		.apb_cpl (bank_a_cpl)
	);

	// Region 1, slow bank
	apb_regbank #(
		.WAITS (apb_pkg::BANK_B_WAITS)
	) u_bank_b (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.apb_req (bank_b_req),
		.apb_cpl (bank_b_cpl)
	);

endmodule

`default_nettype wire

/* testbench/tb_apb_subsystem.sv */
// Testbench for the APB subsystem.
// Reads every bank word after reset, runs random commands over the req/ack
// port, then reads every word again. Each response, the ack latency and the
// handshake order are checked against a memory model of the two banks.

`default_nettype none

module tb_apb_subsystem;

	// ----------------------------------------------------------------------
	// Run length and timing
	// ----------------------------------------------------------------------
	localparam int CLK_PERIOD     = 4;
	localparam int NUM_CMDS       = 1500;
	localparam int SWEEP_CMDS     = 2 * apb_pkg::BANK_WORDS;
	localparam int CYCLES_PER_CMD = 16;
	// Sweeps after reset and at the end come on top of the random commands
	localparam int WATCHDOG_TIME  =
		(NUM_CMDS + 2 * SWEEP_CMDS) * CYCLES_PER_CMD * CLK_PERIOD;
	// Ack latency is 3 cycles plus the completer's wait states
	localparam int ACK_LAT_FAST   = 3;
	localparam int ACK_LAT_SLOW   = 3 + 2;

	logic              CLK;
	logic              rst_n;
	logic              cmd_req;
	apb_pkg::apb_cmd_t cmd;
	logic              cmd_ack;
	apb_pkg::apb_rsp_t rsp;

	// Model of the two banks
	logic [31:0] model_a [16];
	logic [31:0] model_b [16];

	integer seed;
	int     cmd_index;

	apb_subsystem_top u_dut (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.cmd_req (cmd_req),
		.cmd     (cmd),
		.cmd_ack (cmd_ack),
		.rsp     (rsp)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// ----------------------------------------------------------------------
	// Failure reporting and compare tasks
	// ----------------------------------------------------------------------
	task automatic report_failure(input string what);
		$display("%s (command %0d)", what, cmd_index);
		$display("Verification failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_rsp(input apb_pkg::apb_rsp_t expected,
		input apb_pkg::apb_rsp_t actual);
		if (actual.rdata !== expected.rdata) begin
			report_failure($sformatf("Mismatch rsp.rdata: expected 0x%08h, got 0x%08h",
				expected.rdata, actual.rdata));
		end else if (actual.slverr !== expected.slverr) begin
			report_failure($sformatf("Mismatch rsp.slverr: expected 0x%0h, got 0x%0h",
				expected.slverr, actual.slverr));
		end
	endtask

	task automatic check_ack(input logic expected, input logic actual);
		if (actual !== expected) begin
			report_failure($sformatf("Mismatch cmd_ack: expected 0x%0h, got 0x%0h",
				expected, actual));
		end
	endtask

	// ----------------------------------------------------------------------
	// Model and stimulus
	// ----------------------------------------------------------------------
	function automatic logic [31:0] next_rand();
		next_rand = $random(seed);
	endfunction

	// Expected response and ack latency, bank model updated for writes
	task automatic model_command(input apb_pkg::apb_cmd_t c,
		output apb_pkg::apb_rsp_t exp, output int lat);
		logic [3:0]  region;
		logic [3:0]  idx;
		logic [31:0] word;
		int          b;
		region     = c.addr[11:8];
		idx        = c.addr[5:2];
		lat        = (region == 4'd1) ? ACK_LAT_SLOW : ACK_LAT_FAST;
		exp.rdata  = '0;
		exp.slverr = 1'b1;
		// Only regions 0 and 1 with offset bits 7 to 6 clear reach a word
		if ((region < 4'd2) && (c.addr[7:6] == 2'b00)) begin
			word       = (region == 4'd0) ? model_a[idx] : model_b[idx];
			exp.slverr = 1'b0;
			if (c.dir == apb_pkg::APB_WRITE) begin
				for (b = 0; b < 4; b++) begin
					if (c.strb[b]) begin
						word[b*8 +: 8] = c.wdata[b*8 +: 8];
					end
				end
				if (region == 4'd0) begin
					model_a[idx] = word;
				end else begin
					model_b[idx] = word;
				end
			end else begin
				exp.rdata = word;
			end
		end
	endtask

	// Mostly in-range bank accesses, some bad offsets, some unmapped regions
	task automatic random_command(output apb_pkg::apb_cmd_t c, output int hold);
		logic [31:0] r;
		logic [3:0]  region;
		logic [1:0]  oor;
		r      = next_rand();
		oor    = 2'b00;
		region = 4'd0;
		if (r[3:0] < 4'd6) begin
			region = 4'd0;
		end else if (r[3:0] < 4'd12) begin
			region = 4'd1;
		end else if (r[3:0] < 4'd14) begin
			region = {3'b000, r[4]};
			oor    = (r[6:5] == 2'b00) ? 2'b11 : r[6:5];
		end else begin
			region = (r[11:8] < 4'd2) ? r[11:8] + 4'd2 : r[11:8];
		end
		c.addr  = {region, oor, r[15:12], r[17:16]};
		c.dir   = r[18] ? apb_pkg::APB_WRITE : apb_pkg::APB_READ;
		c.strb  = r[25:22];
		c.wdata = next_rand();
		hold    = int'(r[21:20]);
	endtask

	// One full four-phase handshake, called a small delay after a rising edge
	task automatic run_command(input apb_pkg::apb_cmd_t c, input int hold);
		apb_pkg::apb_rsp_t exp;
		int                lat;
		int                n;
		int                h;
		model_command(c, exp, lat);
		cmd_index++;
		check_ack(1'b0, cmd_ack);
		cmd     = c;
		cmd_req = 1'b1;
		n       = 0;
		// Ack must stay low until exactly the expected edge
		while (cmd_ack !== 1'b1) begin
			@(posedge CLK);
			#1;
			n++;
			check_ack(n >= lat, cmd_ack);
		end
		check_rsp(exp, rsp);
		// Slow issuer, response and ack must hold
		for (h = 0; h < hold; h++) begin
			@(posedge CLK);
			#1;
			check_ack(1'b1, cmd_ack);
			check_rsp(exp, rsp);
		end
		cmd_req = 1'b0;
		@(posedge CLK);
		#1;
		check_ack(1'b0, cmd_ack);
	endtask

	// Reads every word of both banks
	task automatic read_sweep();
		apb_pkg::apb_cmd_t c;
		int                i;
		for (i = 0; i < SWEEP_CMDS; i++) begin
			c      = '0;
			c.dir  = apb_pkg::APB_READ;
			c.addr = {3'b000, i[4], 2'b00, i[3:0], 2'b00};
			run_command(c, 0);
		end
	endtask

	// ----------------------------------------------------------------------
	// Main sequence and watchdog
	// ----------------------------------------------------------------------
	initial begin
		apb_pkg::apb_cmd_t c;
		int                hold;
		int                i;
		seed      = 32'h8159_8f67;
		cmd_index = 0;
		CLK       = 1'b0;
		rst_n     = 1'b0;
		cmd_req   = 1'b0;
		cmd       = '0;
		for (i = 0; i < 16; i++) begin
			model_a[i] = '0;
			model_b[i] = '0;
		end
		repeat (3) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		// Banks must read back zero after reset
		read_sweep();
		for (i = 0; i < NUM_CMDS; i++) begin
			random_command(c, hold);
			run_command(c, hold);
		end
		// Final contents, catches writes that leaked through errors
		read_sweep();
		$display("Verification passed");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired after %0d time units before the run finished",
			WATCHDOG_TIME);
		$display("Verification failed");
		$fatal(1, "Timeout");
	end

endmodule

`default_nettype wire
